/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := apb5_stub_tb
FILELIST := apb5_stub.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

# The pass line in the log decides the result
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* apb5_stub.f */
+incdir+include
source/apb5_pkg.sv
source/skid_fifo.sv
source/apb5_slave_stub.sv
source/apb5_reg_target.sv
source/apb5_stub_top.sv
bench/apb5_stub_tb.sv

/* bench/apb5_stub_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apb5_consts.svh"

module apb5_stub_tb;

    import apb5_pkg::*;

    localparam int NUM_XFERS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_XFERS * 12 + 100;

    logic     pclk;
    logic     arst_n;
    logic     psel;
    logic     penable;
    addr_t    paddr;
    logic     pwrite;
    data_t    pwdata;
    strb_t    pstrb;
    prot_t    pprot;
    auser_t   pauser;
    wuser_t   pwuser;
    strb_t    pwdataparity;
    logic     paddrparity;
    logic     pctrlparity;
    logic     wakeup_request;
    data_t    prdata;
    logic     pslverr;
    logic     pready;
    logic     pwakeup;
    ruser_t   pruser;
    buser_t   pbuser;
    strb_t    prdataparity;
    logic     preadyparity;
    logic     pslverrparity;
    logic     parity_error_wdata;
    logic     parity_error_ctrl;

    // Reference copy of the register bank
    data_t       model [`APB5_BANK_WORDS];
    logic [15:0] lfsr;
    logic        last_wake;
    logic        exp_perr_wdata;
    logic        exp_perr_ctrl;
    int          cycle_count;

    apb5_stub_top UUT (
        .pclk               (pclk),
        .arst_n             (arst_n),
        .psel               (psel),
        .penable            (penable),
        .paddr              (paddr),
        .pwrite             (pwrite),
        .pwdata             (pwdata),
        .pstrb              (pstrb),
        .pprot              (pprot),
        .pauser             (pauser),
        .pwuser             (pwuser),
        .pwdataparity       (pwdataparity),
        .paddrparity        (paddrparity),
        .pctrlparity        (pctrlparity),
        .wakeup_request     (wakeup_request),
        .prdata             (prdata),
        .pslverr            (pslverr),
        .pready             (pready),
        .pwakeup            (pwakeup),
        .pruser             (pruser),
        .pbuser             (pbuser),
        .prdataparity       (prdataparity),
        .preadyparity       (preadyparity),
        .pslverrparity      (pslverrparity),
        .parity_error_wdata (parity_error_wdata),
        .parity_error_ctrl  (parity_error_ctrl)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    always @(posedge pclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run hung and did not finish within %0d cycles", cycle_count);
            $display("sim failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %t: %s expected 0x%0h, got 0x%0h", $realtime, name,
                     expected, actual);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Per-cycle checks on the falling edge and a new wake-up request
    task automatic tick();
        @(negedge pclk);
        check_value("pwakeup", 32'(last_wake), 32'(pwakeup));
        check_value("parity_error_wdata", 32'(exp_perr_wdata), 32'(parity_error_wdata));
        check_value("parity_error_ctrl", 32'(exp_perr_ctrl), 32'(parity_error_ctrl));
        wakeup_request = (rand_bits(1) != 0);
        last_wake      = wakeup_request;
    endtask

    task automatic idle_cycle();
        tick();
        psel           = 1'b0;
        penable        = 1'b0;
        exp_perr_wdata = 1'b0;
        exp_perr_ctrl  = 1'b0;
    endtask

    task automatic run_transfer(input logic wr, input addr_t addr, input data_t wdata,
                                input strb_t strb, input prot_t prot, input auser_t au,
                                input wuser_t wu, input strb_t wmask, input logic aflip,
                                input logic cflip);
        logic [3:0] widx;
        logic       exp_err;
        data_t      exp_rdata;
        strb_t      exp_rpar;
        // Bank rules allow words 0..15 only and the upper half needs PPROT[0]
        widx      = addr[5:2];
        exp_err   = (addr[`APB5_ADDR_W-1:6] != '0) ||
                    ((widx >= 4'(`APB5_PRIV_BASE)) && !prot[0]);
        exp_rdata = (!wr && !exp_err) ? model[widx] : '0;
        if (wr && !exp_err) begin
            for (int b = 0; b < `APB5_STRB_W; b++) begin
                if (strb[b]) begin
                    model[widx][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
        for (int b = 0; b < `APB5_STRB_W; b++) begin
            exp_rpar[b] = ^exp_rdata[b*8 +: 8];
        end

        // Setup phase
        tick();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        pstrb   = strb;
        pprot   = prot;
        pauser  = au;
        pwuser  = wu;
        for (int b = 0; b < `APB5_STRB_W; b++) begin
            pwdataparity[b] = (^wdata[b*8 +: 8]) ^ wmask[b];
        end
        paddrparity    = (^addr) ^ aflip;
        pctrlparity    = (^{wr, strb, prot}) ^ cflip;
        exp_perr_wdata = 1'b0;
        exp_perr_ctrl  = 1'b0;

        // Access phase held until pready
        tick();
        check_value("pready", 32'(1'b0), 32'(pready));
        check_value("preadyparity", 32'(1'b0), 32'(preadyparity));
        penable        = 1'b1;
        exp_perr_wdata = (wmask != '0);
        exp_perr_ctrl  = aflip || cflip;
        tick();
        while (pready !== 1'b1) begin
            tick();
        end

        check_value("pslverr", 32'(exp_err), 32'(pslverr));
        check_value("prdata", exp_rdata, prdata);
        check_value("pruser", 32'(au), 32'(pruser));
        check_value("pbuser", 32'(wu), 32'(pbuser));
        check_value("prdataparity", 32'(exp_rpar), 32'(prdataparity));
        check_value("preadyparity", 32'(1'b1), 32'(preadyparity));
        check_value("pslverrparity", 32'(exp_err), 32'(pslverrparity));
    endtask

    initial begin
        logic   wr;
        int     word;
        addr_t  addr;
        strb_t  strb;
        strb_t  wmask;
        $timeformat(-9, 1, " ns", 8);
        lfsr           = 16'd49225;
        cycle_count    = 0;
        last_wake      = 1'b0;
        exp_perr_wdata = 1'b0;
        exp_perr_ctrl  = 1'b0;
        arst_n         = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        paddr          = '0;
        pwrite         = 1'b0;
        pwdata         = '0;
        pstrb          = '0;
        pprot          = '0;
        pauser         = '0;
        pwuser         = '0;
        pwdataparity   = '0;
        paddrparity    = 1'b0;
        pctrlparity    = 1'b0;
        wakeup_request = 1'b0;

        repeat (2) @(posedge pclk);
        @(negedge pclk);
        arst_n = 1'b1;

        // Fill every word first since the bank has no reset
        for (int i = 0; i < `APB5_BANK_WORDS; i++) begin
            run_transfer(1'b1, addr_t'(i) << 2, rand_bits(32), 4'hF, 3'b001,
                         auser_t'(rand_bits(4)), wuser_t'(rand_bits(4)), '0, 1'b0, 1'b0);
        end

        for (int n = 0; n < NUM_XFERS; n++) begin
            wr   = (rand_bits(1) != 0);
            word = int'(rand_bits(5) % 20);
            addr = addr_t'(word) << 2;
            if (rand_bits(3) == 0) begin
                addr = addr | (32'h40 << (rand_bits(5) % 26));
            end
            // APB reads carry no strobes
            strb  = wr ? strb_t'(rand_bits(4)) : '0;
            wmask = '0;
            if (rand_bits(3) == 0) begin
                wmask = strb_t'(rand_bits(4) | 32'h1);
            end
            run_transfer(wr, addr, rand_bits(32), strb, prot_t'(rand_bits(3)),
                         auser_t'(rand_bits(4)), wuser_t'(rand_bits(4)), wmask,
                         rand_bits(4) == 0, rand_bits(4) == 0);
            if (rand_bits(2) == 0) begin
                idle_cycle();
            end
        end

        idle_cycle();
        tick();
        tick();

        $display("sim passed");
        $finish;
    end

endmodule : apb5_stub_tb

`default_nettype wire

/* include/apb5_consts.svh */
`ifndef APB5_CONSTS_SVH
`define APB5_CONSTS_SVH

// APB5 bus widths
`define APB5_DATA_W 32
`define APB5_ADDR_W 32
`define APB5_STRB_W 4
`define APB5_PROT_W 3

// Shared by PAUSER, PWUSER, PRUSER and PBUSER
`define APB5_USER_W 4

// Register bank geometry
`define APB5_BANK_WORDS 16

// Words from here up need PPROT[0] set
`define APB5_PRIV_BASE 8

// Entries in each skid FIFO
`define APB5_FIFO_DEPTH 2

`endif

/* source/apb5_pkg.sv */
`default_nettype none

`include "apb5_consts.svh"

package apb5_pkg;

    // Bus field types
    typedef logic [`APB5_ADDR_W-1:0] addr_t;
    typedef logic [`APB5_DATA_W-1:0] data_t;
    typedef logic [`APB5_STRB_W-1:0] strb_t;
    typedef logic [`APB5_PROT_W-1:0] prot_t;

    // User attribute fields
    typedef logic [`APB5_USER_W-1:0] auser_t;
    typedef logic [`APB5_USER_W-1:0] wuser_t;
    typedef logic [`APB5_USER_W-1:0] ruser_t;
    typedef logic [`APB5_USER_W-1:0] buser_t;

    // One APB access, front end to target
    typedef struct packed {
        logic   write;
        prot_t  prot;
        strb_t  strb;
        addr_t  addr;
        data_t  wdata;
        auser_t auser;
        wuser_t wuser;
    } apb5_cmd_t;

    // Completion, target back to front end
    typedef struct packed {
        logic   slverr;
        data_t  rdata;
        ruser_t ruser;
        buser_t buser;
    } apb5_rsp_t;

    // Front-end FSM, one-hot
    typedef enum logic [1:0] {
        IDLE      = 2'b01,
        XFER_DATA = 2'b10
    } fe_state_t;

endpackage : apb5_pkg

`default_nettype wire

/* source/apb5_reg_target.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apb5_consts.svh"

module apb5_reg_target (
    input  logic                pclk,
    input  logic                arst_n,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  apb5_pkg::apb5_cmd_t cmd_data,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output apb5_pkg::apb5_rsp_t rsp_data
);

    import apb5_pkg::*;

    localparam int WIDX_W = $clog2(`APB5_BANK_WORDS);
    localparam logic [WIDX_W-1:0] PRIV_IDX = WIDX_W'(`APB5_PRIV_BASE);

    data_t             bank [`APB5_BANK_WORDS];
    logic [WIDX_W-1:0] widx;
    logic              addr_err;
    logic              priv_err;
    logic              err;
    logic              accept;
    apb5_rsp_t         rsp_next;

    // Word index from bits 5:2, everything above must be zero
    assign widx     = cmd_data.addr[WIDX_W+1:2];
    assign addr_err = |cmd_data.addr[`APB5_ADDR_W-1:WIDX_W+2];
    // Upper words need a privileged access
    assign priv_err = (widx >= PRIV_IDX) && !cmd_data.prot[0];
    assign err      = addr_err || priv_err;

    // One command in flight at a time
    assign cmd_ready = !rsp_valid;
    assign accept    = cmd_valid && cmd_ready;

    always_comb begin
        rsp_next.slverr = err;
        rsp_next.rdata  = (!cmd_data.write && !err) ? bank[widx] : '0;
        rsp_next.ruser  = cmd_data.auser;
        rsp_next.buser  = cmd_data.wuser;
    end

    // Byte-enabled write, dropped on error
    always_ff @(posedge pclk) begin
        if (accept && cmd_data.write && !err) begin
            for (int b = 0; b < `APB5_STRB_W; b++) begin
                if (cmd_data.strb[b]) begin
                    bank[widx][b*8 +: 8] <= cmd_data.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (accept) begin
            rsp_data <= rsp_next;
        end
    end

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Response stays up until the FIFO takes it
    a_rsp_hold: assert property (@(posedge pclk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule : apb5_reg_target

`default_nettype wire

/* source/apb5_slave_stub.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apb5_consts.svh"

module apb5_slave_stub (
    input  logic                pclk,
    input  logic                arst_n,

    // APB5 request side
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  apb5_pkg::addr_t     paddr,
    input  apb5_pkg::data_t     pwdata,
    input  apb5_pkg::strb_t     pstrb,
    input  apb5_pkg::prot_t     pprot,
    input  apb5_pkg::auser_t    pauser,
    input  apb5_pkg::wuser_t    pwuser,
    input  apb5_pkg::strb_t     pwdataparity,
    input  logic                paddrparity,
    input  logic                pctrlparity,
    input  logic                wakeup_request,

    // APB5 completion side
    output apb5_pkg::data_t     prdata,
    output logic                pslverr,
    output logic                pready,
    output logic                pwakeup,
    output apb5_pkg::ruser_t    pruser,
    output apb5_pkg::buser_t    pbuser,
    output apb5_pkg::strb_t     prdataparity,
    output logic                preadyparity,
    output logic                pslverrparity,

    // Command and response streams
    output logic                cmd_valid,
    input  logic                cmd_ready,
    output apb5_pkg::apb5_cmd_t cmd_data,
    input  logic                rsp_valid,
    output logic                rsp_ready,
    input  apb5_pkg::apb5_rsp_t rsp_data,

    output logic                parity_error_wdata,
    output logic                parity_error_ctrl
);

    import apb5_pkg::*;

    fe_state_t state;
    fe_state_t state_next;
    logic      access;
    strb_t     wdata_par_exp;
    logic      addr_par_exp;
    logic      ctrl_par_exp;

    assign access = psel && penable;

    // Wake-up follows the request one cycle late
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            pwakeup <= 1'b0;
        end else begin
            pwakeup <= wakeup_request;
        end
    end

    // Even parity per byte lane
    always_comb begin
        for (int i = 0; i < `APB5_STRB_W; i++) begin
            wdata_par_exp[i] = ^pwdata[i*8 +: 8];
            prdataparity[i]  = ^prdata[i*8 +: 8];
        end
    end

    assign addr_par_exp = ^paddr;
    assign ctrl_par_exp = ^{pwrite, pstrb, pprot};

    // Checked only while the access phase is up
    assign parity_error_wdata = access && (wdata_par_exp != pwdataparity);
    assign parity_error_ctrl  = access && ((addr_par_exp != paddrparity) ||
                                           (ctrl_par_exp != pctrlparity));

    assign preadyparity  = pready;
    assign pslverrparity = pslverr;

    // Request fields are held by the master for the whole access phase
    assign cmd_data = '{
        write: pwrite,
        prot:  pprot,
        strb:  pstrb,
        addr:  paddr,
        wdata: pwdata,
        auser: pauser,
        wuser: pwuser
    };

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        cmd_valid  = 1'b0;
        rsp_ready  = 1'b0;
        pready     = 1'b0;
        pslverr    = 1'b0;
        prdata     = '0;
        pruser     = '0;
        pbuser     = '0;
        unique case (state)
            IDLE: begin
                // Offer the command; move on once the FIFO takes it
                cmd_valid = access;
                if (access && cmd_ready) begin
                    state_next = XFER_DATA;
                end
            end
            XFER_DATA: begin
                if (rsp_valid) begin
                    pready     = 1'b1;
                    pslverr    = rsp_data.slverr;
                    prdata     = rsp_data.rdata;
                    pruser     = rsp_data.ruser;
                    pbuser     = rsp_data.buser;
                    rsp_ready  = 1'b1;
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // Completion only inside a live access phase
    a_pready_in_xfer: assert property (@(posedge pclk) disable iff (!arst_n)
        pready |-> (state == XFER_DATA) && psel && penable);

    // No stale response is left when a new command goes out
    a_cmd_no_rsp: assert property (@(posedge pclk) disable iff (!arst_n)
        cmd_valid |-> !rsp_valid);

endmodule : apb5_slave_stub

`default_nettype wire

/* source/apb5_stub_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apb5_stub_top (
    input  logic             pclk,
    input  logic             arst_n,
    input  logic             psel,
    input  logic             penable,
    input  apb5_pkg::addr_t  paddr,
    input  logic             pwrite,
    input  apb5_pkg::data_t  pwdata,
    input  apb5_pkg::strb_t  pstrb,
    input  apb5_pkg::prot_t  pprot,
    input  apb5_pkg::auser_t pauser,
    input  apb5_pkg::wuser_t pwuser,
    input  apb5_pkg::strb_t  pwdataparity,
    input  logic             paddrparity,
    input  logic             pctrlparity,
    input  logic             wakeup_request,
    output apb5_pkg::data_t  prdata,
    output logic             pslverr,
    output logic             pready,
    output logic             pwakeup,
    output apb5_pkg::ruser_t pruser,
    output apb5_pkg::buser_t pbuser,
    output apb5_pkg::strb_t  prdataparity,
    output logic             preadyparity,
    output logic             pslverrparity,
    output logic             parity_error_wdata,
    output logic             parity_error_ctrl
);

    import apb5_pkg::*;

    // Front end to command FIFO
    logic      fe_cmd_valid;
    logic      fe_cmd_ready;
    apb5_cmd_t fe_cmd_data;
    // Command FIFO to target
    logic      tgt_cmd_valid;
    logic      tgt_cmd_ready;
    apb5_cmd_t tgt_cmd_data;
    // Target to response FIFO
    logic      tgt_rsp_valid;
    logic      tgt_rsp_ready;
    apb5_rsp_t tgt_rsp_data;
    // Response FIFO to front end
    logic      fe_rsp_valid;
    logic      fe_rsp_ready;
    apb5_rsp_t fe_rsp_data;

    apb5_slave_stub u_slave (
        .pclk               (pclk),
        .arst_n             (arst_n),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .paddr              (paddr),
        .pwdata             (pwdata),
        .pstrb              (pstrb),
        .pprot              (pprot),
        .pauser             (pauser),
        .pwuser             (pwuser),
        .pwdataparity       (pwdataparity),
        .paddrparity        (paddrparity),
        .pctrlparity        (pctrlparity),
        .wakeup_request     (wakeup_request),
        .prdata             (prdata),
        .pslverr            (pslverr),
        .pready             (pready),
        .pwakeup            (pwakeup),
        .pruser             (pruser),
        .pbuser             (pbuser),
        .prdataparity       (prdataparity),
        .preadyparity       (preadyparity),
        .pslverrparity      (pslverrparity),
        .cmd_valid          (fe_cmd_valid),
        .cmd_ready          (fe_cmd_ready),
        .cmd_data           (fe_cmd_data),
        .rsp_valid          (fe_rsp_valid),
        .rsp_ready          (fe_rsp_ready),
        .rsp_data           (fe_rsp_data),
        .parity_error_wdata (parity_error_wdata),
        .parity_error_ctrl  (parity_error_ctrl)
    );

    skid_fifo #(
        .WIDTH($bits(apb5_cmd_t))
    ) cmd_fifo (
        .pclk      (pclk),
        .arst_n    (arst_n),
        .in_valid  (fe_cmd_valid),
        .in_ready  (fe_cmd_ready),
        .in_data   (fe_cmd_data),
        .out_valid (tgt_cmd_valid),
        .out_ready (tgt_cmd_ready),
        .out_data  (tgt_cmd_data)
    );

    apb5_reg_target u_target (
        .pclk      (pclk),
        .arst_n    (arst_n),
        .cmd_valid (tgt_cmd_valid),
        .cmd_ready (tgt_cmd_ready),
        .cmd_data  (tgt_cmd_data),
        .rsp_valid (tgt_rsp_valid),
        .rsp_ready (tgt_rsp_ready),
        .rsp_data  (tgt_rsp_data)
    );

    skid_fifo #(
        .WIDTH($bits(apb5_rsp_t))
    ) rsp_fifo (
        .pclk      (pclk),
        .arst_n    (arst_n),
        .in_valid  (tgt_rsp_valid),
        .in_ready  (tgt_rsp_ready),
        .in_data   (tgt_rsp_data),
        .out_valid (fe_rsp_valid),
        .out_ready (fe_rsp_ready),
        .out_data  (fe_rsp_data)
    );

endmodule : apb5_stub_top

`default_nettype wire

/* source/skid_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apb5_consts.svh"

module skid_fifo #(
    parameter int WIDTH = 8
) (
    input  logic             pclk,
    input  logic             arst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    localparam int CNT_W = $clog2(`APB5_FIFO_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`APB5_FIFO_DEPTH);

    logic [WIDTH-1:0] entry [`APB5_FIFO_DEPTH];
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Ready comes from the count alone, no path from out_ready
    assign in_ready  = (count != FULL_CNT);
    assign out_valid = (count != '0);
    assign out_data  = entry[0];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Entry 0 is always the head
    always_ff @(posedge pclk) begin
        if (pop) begin
            if (count == FULL_CNT) begin
                entry[0] <= entry[1];
            end else if (push) begin
                entry[0] <= in_data;
            end
        end else if (push) begin
            if (count == '0) begin
                entry[0] <= in_data;
            end else begin
                entry[1] <= in_data;
            end
        end
    end

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // A full buffer can only drain
    a_no_push_full: assert property (@(posedge pclk) disable iff (!arst_n)
        (count == FULL_CNT) |=> (count == FULL_CNT - CNT_W'($past(pop))));

    a_hold_stall: assert property (@(posedge pclk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule : skid_fifo

`default_nettype wire
